// ==== source/geometry_pkg.sv ====
package geometry_pkg;

    // screen coordinate and signed per-frame displacement
    typedef logic [9:0] coord_t;
    typedef logic signed [9:0] vel_t;

    localparam coord_t SCREEN_X_MAX = 10'd639;
    localparam coord_t SCREEN_Y_MAX = 10'd479;

    // top edge of a sprite standing on the ground
    localparam coord_t GROUND_Y = 10'd384;
    localparam coord_t START_X = 10'd80;

    // upward motion above this line is turned around
    localparam coord_t CEILING_Y = 10'd5;

endpackage

// ==== source/control_pkg.sv ====
package control_pkg;

    // keyboard scan codes
    localparam logic [7:0] KEY_LEFT = 8'h04;
    localparam logic [7:0] KEY_RIGHT = 8'h07;
    localparam logic [7:0] KEY_JUMP = 8'h1A;

    typedef enum logic [3:0] {
        STAND,
        RUN_1_R,
        RUN_2_R,
        RUN_3_R,
        RUN_1_L,
        RUN_2_L,
        RUN_3_L,
        JUMP,
        IN_AIR,
        DIE
    } motion_state_t;

    // negative is up the screen
    localparam geometry_pkg::vel_t JUMP_VELOCITY = -10'sd15;
    localparam geometry_pkg::vel_t DEATH_VELOCITY = -10'sd15;
    localparam geometry_pkg::vel_t GRAVITY_STEP = 10'sd1;

endpackage

// ==== source/motion_if.sv ====
`timescale 1ns/100ps

interface motion_if;

    // frame tick, both sides update only in this cycle
    logic                 tick;

    geometry_pkg::vel_t   x_motion;
    geometry_pkg::vel_t   y_motion;
    logic                 dying;

    geometry_pkg::coord_t pos_x;
    geometry_pkg::coord_t pos_y;
    logic                 in_air;

    modport fsm_mp (
        input  tick, pos_x, pos_y, in_air,
        output x_motion, y_motion, dying
    );

    modport integ_mp (
        input  tick, x_motion, y_motion, dying,
        output pos_x, pos_y, in_air
    );

endinterface

// ==== source/input_sampler.sv ====
`timescale 1ns/100ps

module input_sampler (
    input  logic       Clk,
    input  logic       arst_n,
    input  logic       frame_clk,
    input  logic [7:0] keycode,
    output logic       tick,
    output logic       key_left,
    output logic       key_right,
    output logic       key_jump
);

    logic frame_sync_1;
    logic frame_sync_2;
    logic frame_prev;

    // two-flop synchronizer, then rising edge to a one-cycle tick
    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            frame_sync_1 <= 1'b0;
            frame_sync_2 <= 1'b0;
            frame_prev   <= 1'b0;
            tick         <= 1'b0;
        end
        else
        begin
            frame_sync_1 <= frame_clk;
            frame_sync_2 <= frame_sync_1;
            frame_prev   <= frame_sync_2;
            tick         <= frame_sync_2 & ~frame_prev;
        end
    end

    // unknown codes release every key
    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            key_left  <= 1'b0;
            key_right <= 1'b0;
            key_jump  <= 1'b0;
        end
        else if (tick)
        begin
            key_left  <= (keycode == control_pkg::KEY_LEFT);
            key_right <= (keycode == control_pkg::KEY_RIGHT);
            key_jump  <= (keycode == control_pkg::KEY_JUMP);
        end
    end

endmodule

// ==== source/motion_fsm.sv ====
`timescale 1ns/100ps

module motion_fsm #(
    parameter int SPRITE_SIZE = 32,
    parameter int RAMP_FRAMES = 8
) (
    input  logic     Clk,
    input  logic     arst_n,
    input  logic     key_left,
    input  logic     key_right,
    input  logic     key_jump,
    input  logic     alive,
    motion_if.fsm_mp motion
);

    localparam int RAMP_W = (RAMP_FRAMES > 1) ? $clog2(RAMP_FRAMES) : 1;
    // fall speed saturates here so the velocity never wraps
    localparam geometry_pkg::vel_t VEL_MAX = 10'sd511;

    control_pkg::motion_state_t state;
    control_pkg::motion_state_t state_next;
    geometry_pkg::vel_t         x_next;
    geometry_pkg::vel_t         y_next;
    geometry_pkg::vel_t         run_mag;
    geometry_pkg::vel_t         run_vel;
    logic [RAMP_W-1:0]          ramp_cnt;
    logic [RAMP_W-1:0]          ramp_next;
    logic                       jump_latch;
    logic                       latch_next;
    logic                       run_right;
    logic                       run_left;
    logic                       run_key;
    logic                       ramp_done;
    logic                       at_edge;
    logic [1:0]                 run_speed;
    logic signed [10:0]         x_sum;
    logic signed [10:0]         y_sum;
    logic [10:0]                right_end;

    function automatic control_pkg::motion_state_t run_state(
        input logic       right,
        input logic [1:0] speed
    );
        control_pkg::motion_state_t result;
        case (speed)
            2'd1:    result = right ? control_pkg::RUN_1_R : control_pkg::RUN_1_L;
            2'd2:    result = right ? control_pkg::RUN_2_R : control_pkg::RUN_2_L;
            default: result = right ? control_pkg::RUN_3_R : control_pkg::RUN_3_L;
        endcase
        return result;
    endfunction

    assign run_right = state inside {control_pkg::RUN_1_R, control_pkg::RUN_2_R,
                                     control_pkg::RUN_3_R};
    assign run_left  = state inside {control_pkg::RUN_1_L, control_pkg::RUN_2_L,
                                     control_pkg::RUN_3_L};

    always_comb
    begin
        unique case (state)
            control_pkg::RUN_1_R, control_pkg::RUN_1_L: run_speed = 2'd1;
            control_pkg::RUN_2_R, control_pkg::RUN_2_L: run_speed = 2'd2;
            control_pkg::RUN_3_R, control_pkg::RUN_3_L: run_speed = 2'd3;
            default:                                    run_speed = 2'd0;
        endcase
    end

    assign run_mag   = {8'd0, run_speed};
    assign run_vel   = run_left ? -run_mag : run_mag;
    assign run_key   = run_right ? key_right : key_left;
    assign ramp_done = (ramp_cnt == RAMP_W'(RAMP_FRAMES - 1));

    // screen edge stops the run
    assign x_sum     = $signed({1'b0, motion.pos_x}) + motion.x_motion;
    assign y_sum     = $signed({1'b0, motion.pos_y}) + motion.y_motion;
    assign right_end = {1'b0, motion.pos_x} + 11'(SPRITE_SIZE);
    assign at_edge   = run_right ? (right_end >= {1'b0, geometry_pkg::SCREEN_X_MAX})
                                 : (x_sum <= 11'sd1);

    always_comb
    begin
        state_next = state;
        x_next     = motion.x_motion;
        y_next     = motion.y_motion;
        ramp_next  = '0;
        latch_next = jump_latch;
        unique case (state)
            control_pkg::STAND, control_pkg::RUN_1_R, control_pkg::RUN_2_R,
            control_pkg::RUN_3_R, control_pkg::RUN_1_L, control_pkg::RUN_2_L,
            control_pkg::RUN_3_L:
            begin
                x_next = at_edge ? 10'sd0 : run_vel;
                y_next = 10'sd0;
                if (!key_jump)
                    latch_next = 1'b0;
                if (!alive)
                begin
                    state_next = control_pkg::DIE;
                    x_next     = 10'sd0;
                    y_next     = control_pkg::DEATH_VELOCITY;
                end
                else if (key_jump && !jump_latch)
                begin
                    state_next = control_pkg::JUMP;
                    latch_next = 1'b1;
                end
                else if (state == control_pkg::STAND)
                begin
                    if (key_left)
                        state_next = control_pkg::RUN_1_L;
                    else if (key_right)
                        state_next = control_pkg::RUN_1_R;
                end
                else if (run_key)
                begin
                    // top speed just holds
                    if (run_speed != 2'd3 && ramp_done)
                        state_next = run_state(run_right, run_speed + 2'd1);
                    else if (run_speed != 2'd3)
                        ramp_next = ramp_cnt + 1'b1;
                end
                else if (run_speed == 2'd3)
                    state_next = run_state(run_right, 2'd1);
                else
                    state_next = control_pkg::STAND;
            end

            control_pkg::JUMP:
            begin
                y_next     = control_pkg::JUMP_VELOCITY;
                latch_next = 1'b1;
                state_next = control_pkg::IN_AIR;
            end

            control_pkg::IN_AIR:
            begin
                latch_next = 1'b1;
                if (!alive)
                begin
                    state_next = control_pkg::DIE;
                    x_next     = 10'sd0;
                    y_next     = control_pkg::DEATH_VELOCITY;
                end
                else if (motion.in_air)
                begin
                    if (y_sum < $signed({1'b0, geometry_pkg::CEILING_Y}))
                        y_next = -motion.y_motion;
                    else
                        y_next = motion.y_motion + control_pkg::GRAVITY_STEP;
                end
                else
                begin
                    // landed, a held key still blocks the next jump
                    state_next = control_pkg::STAND;
                    y_next     = 10'sd0;
                    latch_next = key_jump;
                end
            end

            control_pkg::DIE:
            begin
                x_next = 10'sd0;
                if (motion.y_motion != VEL_MAX)
                    y_next = motion.y_motion + control_pkg::GRAVITY_STEP;
            end

            default: state_next = control_pkg::STAND;
        endcase
    end

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state           <= control_pkg::STAND;
            motion.x_motion <= 10'sd0;
            motion.y_motion <= 10'sd0;
            ramp_cnt        <= '0;
            jump_latch      <= 1'b0;
        end
        else if (motion.tick)
        begin
            state           <= state_next;
            motion.x_motion <= x_next;
            motion.y_motion <= y_next;
            ramp_cnt        <= ramp_next;
            jump_latch      <= latch_next;
        end
    end

    assign motion.dying = (state == control_pkg::DIE);

endmodule

// ==== source/position_integrator.sv ====
`timescale 1ns/100ps

module position_integrator #(
    parameter int SPRITE_SIZE = 32
) (
    input  logic       Clk,
    input  logic       arst_n,
    motion_if.integ_mp motion
);

    // rightmost x that keeps the whole sprite on screen
    localparam int X_LIMIT = int'(geometry_pkg::SCREEN_X_MAX) - SPRITE_SIZE;

    logic signed [11:0]   x_sum;
    logic signed [11:0]   y_sum;
    geometry_pkg::coord_t x_next;
    geometry_pkg::coord_t y_next;

    assign x_sum = $signed({2'b00, motion.pos_x}) + motion.x_motion;
    assign y_sum = $signed({2'b00, motion.pos_y}) + motion.y_motion;

    assign motion.in_air = (y_sum < $signed({2'b00, geometry_pkg::GROUND_Y}));

    always_comb
    begin
        if (x_sum < 0)
            x_next = '0;
        else if (x_sum > X_LIMIT)
            x_next = geometry_pkg::coord_t'(X_LIMIT);
        else
            x_next = x_sum[9:0];

        if (motion.in_air || motion.dying)
        begin
            if (y_sum < 0)
                y_next = '0;
            else if (motion.dying && y_sum >= $signed({2'b00, geometry_pkg::SCREEN_Y_MAX}))
                y_next = geometry_pkg::SCREEN_Y_MAX;
            else
                y_next = y_sum[9:0];
        end
        else
            y_next = geometry_pkg::GROUND_Y;
    end

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            motion.pos_x <= geometry_pkg::START_X;
            motion.pos_y <= geometry_pkg::GROUND_Y;
        end
        else if (motion.tick)
        begin
            motion.pos_x <= x_next;
            motion.pos_y <= y_next;
        end
    end

endmodule

// ==== source/sprite_hit.sv ====
`timescale 1ns/100ps

module sprite_hit #(
    parameter int SPRITE_SIZE = 32
) (
    input  geometry_pkg::coord_t pos_x,
    input  geometry_pkg::coord_t pos_y,
    input  geometry_pkg::coord_t draw_x,
    input  geometry_pkg::coord_t draw_y,
    output logic                 on_sprite
);

    logic [10:0] x_end;
    logic [10:0] y_end;

    // box is open on the right, closed at the bottom
    assign x_end = {1'b0, pos_x} + 11'(SPRITE_SIZE);
    assign y_end = {1'b0, pos_y} + 11'(SPRITE_SIZE);

    assign on_sprite = (draw_x >= pos_x) && ({1'b0, draw_x} < x_end) &&
                       (draw_y >= pos_y) && ({1'b0, draw_y} <= y_end);

endmodule

// ==== source/player_top.sv ====
`timescale 1ns/100ps

module player_top #(
    parameter int SPRITE_SIZE = 32,
    parameter int RAMP_FRAMES = 8
) (
    input  logic                 Clk,
    input  logic                 arst_n,
    input  logic                 frame_clk,
    input  logic [7:0]           keycode,
    input  logic                 alive,
    input  geometry_pkg::coord_t draw_x,
    input  geometry_pkg::coord_t draw_y,
    output geometry_pkg::coord_t pos_x,
    output geometry_pkg::coord_t pos_y,
    output logic                 in_air,
    output logic                 on_sprite
);

    logic key_left;
    logic key_right;
    logic key_jump;

    motion_if motion_bus ();

    input_sampler u_input_sampler (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .frame_clk (frame_clk),
        .keycode   (keycode),
        .tick      (motion_bus.tick),
        .key_left  (key_left),
        .key_right (key_right),
        .key_jump  (key_jump)
    );

    motion_fsm #(
        .SPRITE_SIZE (SPRITE_SIZE),
        .RAMP_FRAMES (RAMP_FRAMES)
    ) u_motion_fsm (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .key_left  (key_left),
        .key_right (key_right),
        .key_jump  (key_jump),
        .alive     (alive),
        .motion    (motion_bus.fsm_mp)
    );

    position_integrator #(
        .SPRITE_SIZE (SPRITE_SIZE)
    ) u_position_integrator (
        .Clk    (Clk),
        .arst_n (arst_n),
        .motion (motion_bus.integ_mp)
    );

    sprite_hit #(
        .SPRITE_SIZE (SPRITE_SIZE)
    ) u_sprite_hit (
        .pos_x     (motion_bus.pos_x),
        .pos_y     (motion_bus.pos_y),
        .draw_x    (draw_x),
        .draw_y    (draw_y),
        .on_sprite (on_sprite)
    );

    assign pos_x  = motion_bus.pos_x;
    assign pos_y  = motion_bus.pos_y;
    assign in_air = motion_bus.in_air;

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic Clk,
    output logic arst_n
);

    initial
    begin
        Clk = 1'b0;
        forever #(PERIOD_NS / 2) Clk = ~Clk;
    end

    // release just after an edge, away from the sampling point
    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge Clk);
        #10;
        arst_n = 1'b1;
    end

endmodule

// ==== testbench/player_tb.sv ====
`timescale 1ns/100ps

module player_tb;

    localparam int SPRITE_SIZE     = 32;
    localparam int RAMP_FRAMES     = 8;
    localparam int CLK_PERIOD      = 100;
    localparam int FRAME_HALF      = 20;
    localparam int FRAME_TIMEOUT   = 4 * FRAME_HALF;
    localparam int WATCHDOG_CYCLES = 60000;

    logic                 Clk;
    logic                 arst_n;
    logic                 frame_clk = 1'b0;
    logic [7:0]           keycode;
    logic                 alive;
    geometry_pkg::coord_t draw_x = '0;
    geometry_pkg::coord_t draw_y = '0;
    geometry_pkg::coord_t pos_x;
    geometry_pkg::coord_t pos_y;
    logic                 in_air;
    logic                 on_sprite;
    logic                 expected_hit;

    int     mismatch_count = 0;
    int     timeout_count = 0;
    int     frame_phase = 0;
    int     draw_pick;
    int     min_y;
    integer seed = 39;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (16)
    ) u_clock_gen (
        .Clk    (Clk),
        .arst_n (arst_n)
    );

    player_top #(
        .SPRITE_SIZE (SPRITE_SIZE),
        .RAMP_FRAMES (RAMP_FRAMES)
    ) dut (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .frame_clk (frame_clk),
        .keycode   (keycode),
        .alive     (alive),
        .draw_x    (draw_x),
        .draw_y    (draw_y),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .in_air    (in_air),
        .on_sprite (on_sprite)
    );

    // box open on the right, closed at the bottom
    function automatic bit box_contains(int px, int py, int dx, int dy);
        return (dx >= px) && (dx < px + SPRITE_SIZE) && (dy >= py) && (dy <= py + SPRITE_SIZE);
    endfunction

    function automatic int edge_offset(int idx);
        case (idx)
            0:       return -1;
            1:       return 0;
            2:       return 1;
            3:       return SPRITE_SIZE - 1;
            4:       return SPRITE_SIZE;
            default: return SPRITE_SIZE + 1;
        endcase
    endfunction

    assign expected_hit = box_contains(int'(pos_x), int'(pos_y), int'(draw_x), int'(draw_y));

    task automatic report_mismatch(input string msg);
        mismatch_count++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic report_timeout(input string msg);
        timeout_count++;
        $display("timeout at %0t: %s", $time, msg);
    endtask

    hit_check: assert property (@(posedge Clk) disable iff (!arst_n) on_sprite == expected_hit)
        else report_mismatch($sformatf("on_sprite %0b for pixel (%0d,%0d) with box at (%0d,%0d)",
                                       on_sprite, draw_x, draw_y, pos_x, pos_y));

    // slow frame strobe, 20 cycles high and 20 low
    always @(posedge Clk)
    begin
        #10;
        frame_phase = (frame_phase == 2 * FRAME_HALF - 1) ? 0 : frame_phase + 1;
        frame_clk = (frame_phase < FRAME_HALF);
    end

    // mostly pixels right at the box edges, some anywhere
    always @(posedge Clk)
    begin
        #10;
        draw_pick = $random(seed) & 3;
        if (draw_pick == 0)
        begin
            draw_x = geometry_pkg::coord_t'($random(seed));
            draw_y = geometry_pkg::coord_t'($random(seed));
        end
        else
        begin
            draw_x = geometry_pkg::coord_t'(int'(pos_x) + edge_offset(($random(seed) & 7) % 6));
            draw_y = geometry_pkg::coord_t'(int'(pos_y) + edge_offset(($random(seed) & 7) % 6));
        end
    end

    task automatic set_inputs(input logic [7:0] code, input logic alive_level);
        @(posedge Clk);
        #10;
        keycode = code;
        alive = alive_level;
    endtask

    task automatic wait_reset_release();
        int n;
        for (n = 0; n < 100 && arst_n !== 1'b1; n++)
            @(posedge Clk);
        if (arst_n !== 1'b1)
            report_timeout("reset was never released");
    endtask

    // returns on the falling frame_clk, long after the position update
    task automatic next_frame();
        int n;
        logic prev;
        bit seen;
        seen = 1'b0;
        prev = frame_clk;
        for (n = 0; n < FRAME_TIMEOUT && !seen; n++)
        begin
            @(posedge Clk);
            seen = prev && !frame_clk;
            prev = frame_clk;
        end
        if (!seen)
            report_timeout("no frame strobe within the expected number of cycles");
    endtask

    task automatic wait_air_level(input logic level, input int max_frames, input string what);
        int f;
        for (f = 0; f < max_frames && in_air !== level; f++)
        begin
            next_frame();
            if (int'(pos_y) < min_y)
                min_y = int'(pos_y);
        end
        if (in_air !== level)
            report_timeout(what);
    endtask

    task automatic check_reset_state();
        for (int f = 0; f < 4; f++)
        begin
            next_frame();
            assert (pos_x == geometry_pkg::START_X && pos_y == geometry_pkg::GROUND_Y && !in_air)
                else report_mismatch($sformatf("idle sprite at (%0d,%0d) with in_air %0b",
                                               pos_x, pos_y, in_air));
        end
    endtask

    task automatic run_right();
        int prev_x;
        int step;
        bit saw_top;
        saw_top = 1'b0;
        prev_x = int'(pos_x);
        set_inputs(control_pkg::KEY_RIGHT, 1'b1);
        for (int f = 1; f <= 3 * RAMP_FRAMES + 200; f++)
        begin
            next_frame();
            step = int'(pos_x) - prev_x;
            assert (step >= 0 && step <= 3)
                else report_mismatch($sformatf("right step %0d at x %0d", step, pos_x));
            assert (int'(pos_x) + SPRITE_SIZE <= int'(geometry_pkg::SCREEN_X_MAX) + 3)
                else report_mismatch($sformatf("sprite past the right edge at x %0d", pos_x));
            if (f > 3 * RAMP_FRAMES && step == 3)
                saw_top = 1'b1;
            prev_x = int'(pos_x);
        end
        assert (saw_top)
            else report_mismatch("right run never moved 3 pixels in one frame");
    endtask

    task automatic run_left();
        int prev_x;
        int step;
        int stable;
        stable = 0;
        prev_x = int'(pos_x);
        set_inputs(control_pkg::KEY_LEFT, 1'b1);
        for (int f = 0; f < 3 * RAMP_FRAMES + 260; f++)
        begin
            next_frame();
            step = prev_x - int'(pos_x);
            assert (step >= 0 && step <= 3)
                else report_mismatch($sformatf("left step %0d at x %0d", step, pos_x));
            stable = (step == 0) ? stable + 1 : 0;
            prev_x = int'(pos_x);
        end
        assert (int'(pos_x) <= 3 && stable >= 8)
            else report_mismatch($sformatf("left run ended at x %0d, still for %0d frames",
                                           pos_x, stable));
    endtask

    task automatic jump_sequence();
        set_inputs(8'h00, 1'b1);
        repeat (4) next_frame();
        min_y = int'(geometry_pkg::GROUND_Y);
        set_inputs(control_pkg::KEY_JUMP, 1'b1);
        wait_air_level(1'b1, 10, "first jump did not leave the ground");
        wait_air_level(1'b0, 60, "first jump did not land");
        // position snaps to the ground one frame after in_air drops
        next_frame();
        assert (min_y < int'(geometry_pkg::GROUND_Y))
            else report_mismatch("first jump never rose above the ground");
        assert (pos_y == geometry_pkg::GROUND_Y)
            else report_mismatch($sformatf("landed at y %0d", pos_y));
        for (int f = 0; f < 10; f++)
        begin
            next_frame();
            assert (!in_air)
                else report_mismatch("jump repeated while the key stayed held");
        end
        set_inputs(8'h00, 1'b1);
        repeat (3) next_frame();
        set_inputs(control_pkg::KEY_JUMP, 1'b1);
        wait_air_level(1'b1, 10, "second jump did not start after a new press");
        set_inputs(8'h00, 1'b1);
        wait_air_level(1'b0, 60, "second jump did not land");
        repeat (2) next_frame();
    endtask

    task automatic death_sequence();
        int ref_x;
        int f;
        set_inputs(8'h00, 1'b0);
        ref_x = int'(pos_x);
        for (f = 0; f < 200 && pos_y != geometry_pkg::SCREEN_Y_MAX; f++)
        begin
            next_frame();
            assert (int'(pos_x) == ref_x)
                else report_mismatch($sformatf("dying sprite moved to x %0d", pos_x));
        end
        if (pos_y != geometry_pkg::SCREEN_Y_MAX)
            report_timeout("dying sprite never reached the bottom of the screen");
        for (f = 0; f < 10; f++)
        begin
            next_frame();
            assert (pos_y == geometry_pkg::SCREEN_Y_MAX && int'(pos_x) == ref_x)
                else report_mismatch($sformatf("dead sprite at (%0d,%0d)", pos_x, pos_y));
        end
    endtask

    initial
    begin
        keycode = 8'h00;
        alive = 1'b1;
        wait_reset_release();
        check_reset_state();
        run_right();
        run_left();
        jump_sequence();
        death_sequence();
        $display("errors: %0d (mismatches %0d, timeouts %0d)",
                 mismatch_count + timeout_count, mismatch_count, timeout_count);
        if (mismatch_count + timeout_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) #(CLK_PERIOD);
        $display("timeout at %0t: the run did not finish within %0d cycles",
                 $time, WATCHDOG_CYCLES);
        $display("errors: %0d (mismatches %0d, timeouts %0d)",
                 mismatch_count + timeout_count + 1, mismatch_count, timeout_count + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== sources.f ====
source/geometry_pkg.sv
source/control_pkg.sv
source/motion_if.sv
source/input_sampler.sv
source/motion_fsm.sv
source/position_integrator.sv
source/sprite_hit.sv
source/player_top.sv
testbench/tb_clock_gen.sv
testbench/player_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module player_tb -f sources.f \
    -o player_sim > build.log 2>&1 \
    && ./obj_dir/player_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
